// ==== Makefile ====
# Verilator lint and simulation for procCore
# override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tbProcCore
FILELIST  ?= procCore.f
BUILD_DIR ?= obj_dir
LINTFLAGS ?= --lint-only --timing
SIMFLAGS  ?= --binary -j 0
PASS_MSG  ?= TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass message appears on a line of its own
sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== common/coreTypesPkg.sv ====
// core types package
// opcode, function-field and execute-operation encodings of the 16-bit ISA,
// plus the data and register-index widths shared by every stage
package coreTypesPkg;

   localparam int WORD_W = 16; // data and instruction width
   localparam int REG_W  = 3;  // register index, eight registers

   // primary opcode, always instr[15:11]
   typedef enum logic [4:0] {
      OP_HALT  = 5'b00000,
      OP_NOP   = 5'b00001,
      OP_ADDI  = 5'b01000,
      OP_SUBI  = 5'b01001,
      OP_XORI  = 5'b01010,
      OP_ANDNI = 5'b01011,
      OP_ROLI  = 5'b10100,
      OP_SLLI  = 5'b10101,
      OP_RORI  = 5'b10110,
      OP_SRLI  = 5'b10111,
      OP_ARITH = 5'b11011, // R-format ADD/SUB/XOR/ANDN by func
      OP_SHIFT = 5'b11010, // R-format ROL/SLL/ROR/SRL by func
      OP_SEQ   = 5'b11100,
      OP_SLT   = 5'b11101,
      OP_SLE   = 5'b11110,
      OP_SCO   = 5'b11111,
      OP_BTR   = 5'b11001,
      OP_LBI   = 5'b11000,
      OP_SLBI  = 5'b10010
   } opcodeT;

   // R-format func field, instr[1:0]
   // arithmetic and shift groups share the same four codes
   typedef enum logic [1:0] {
      FN_ADD_ROL  = 2'b00,
      FN_SUB_SLL  = 2'b01,
      FN_XOR_ROR  = 2'b10,
      FN_ANDN_SRL = 2'b11
   } funcT;

   // operation carried from decode into execute
   typedef enum logic [3:0] {
      ALU_ADD   = 4'd0,  // a + b
      ALU_SUB   = 4'd1,  // b - a
      ALU_XOR   = 4'd2,
      ALU_ANDN  = 4'd3,  // a & ~b
      ALU_ROL   = 4'd4,  // shift amounts use b[3:0]
      ALU_SLL   = 4'd5,
      ALU_ROR   = 4'd6,
      ALU_SRL   = 4'd7,
      ALU_SEQ   = 4'd8,
      ALU_SLT   = 4'd9,  // signed
      ALU_SLE   = 4'd10, // signed
      ALU_SCO   = 4'd11, // carry out of a + b
      ALU_BTR   = 4'd12, // bit reverse of a
      ALU_PASSB = 4'd13, // LBI
      ALU_SLBI  = 4'd14  // (a << 8) | b
   } aluOpT;

endpackage

// ==== decode/decode.sv ====
// decode stage
// reads rs/rt with forwarding from execute and result, extends the
// immediates, picks operand B and the destination, latches HALT and
// registers everything into the decode/execute pipeline register
`timescale 1ns/1ps

module decode import coreTypesPkg::*; (
   input  logic              clk,
   input  logic              arstN,
   input  logic [WORD_W-1:0] instr,
   input  logic              instrValid,
   input  logic [WORD_W-1:0] fwdExData,   // execute stage bypass
   input  logic [REG_W-1:0]  fwdExDest,
   input  logic              fwdExWrite,
   input  logic              rfWriteEn,   // result stage write bus
   input  logic [REG_W-1:0]  rfWriteReg,
   input  logic [WORD_W-1:0] rfWriteData,
   output logic              exValid,
   output aluOpT             exAluOp,
   output logic [WORD_W-1:0] exOpA,
   output logic [WORD_W-1:0] exOpB,
   output logic [REG_W-1:0]  exDest,
   output logic              exWrite,
   output logic              exHalt,
   output logic              exErr
);

   aluOpT             aluOp;
   logic              useImm;
   logic              zeroExt;
   logic              imm8Sel;
   logic              destSel;
   logic              regWrite;
   logic              halt;
   logic              illegal;
   logic              haltSeen;    // sticky once a HALT is accepted
   logic              accept;
   logic [REG_W-1:0]  rsIdx;
   logic [REG_W-1:0]  rtIdx;
   logic [REG_W-1:0]  destIdx;
   logic [WORD_W-1:0] rfDataA;
   logic [WORD_W-1:0] rfDataB;
   logic [WORD_W-1:0] opA;
   logic [WORD_W-1:0] regB;
   logic [WORD_W-1:0] imm5Ext;
   logic [WORD_W-1:0] imm8Ext;
   logic [WORD_W-1:0] immVal;

   // youngest producer wins: execute, then result, then the array
   function automatic logic [WORD_W-1:0] fwdSel(
      input logic [REG_W-1:0]  idx,
      input logic [WORD_W-1:0] arrayData,
      input logic              exHit,
      input logic [REG_W-1:0]  exReg,
      input logic [WORD_W-1:0] exData,
      input logic              rsHit,
      input logic [REG_W-1:0]  rsReg,
      input logic [WORD_W-1:0] rsData
   );
      if (exHit && exReg == idx)
         return exData;
      else if (rsHit && rsReg == idx)
         return rsData;
      else
         return arrayData;
   endfunction

   instrDecoder u_instrDecoder (
      .instr    (instr),
      .aluOp    (aluOp),
      .useImm   (useImm),
      .zeroExt  (zeroExt),
      .imm8Sel  (imm8Sel),
      .destSel  (destSel),
      .regWrite (regWrite),
      .halt     (halt),
      .illegal  (illegal)
   );

   assign rsIdx = instr[10:8];
   assign rtIdx = instr[7:5];

   regFile u_regFile (
      .clk       (clk),
      .arstN     (arstN),
      .readRegA  (rsIdx),
      .readRegB  (rtIdx),
      .readDataA (rfDataA),
      .readDataB (rfDataB),
      .writeEn   (rfWriteEn),
      .writeReg  (rfWriteReg),
      .writeData (rfWriteData)
   );

   assign opA  = fwdSel(rsIdx, rfDataA, fwdExWrite, fwdExDest, fwdExData,
                        rfWriteEn, rfWriteReg, rfWriteData);
   assign regB = fwdSel(rtIdx, rfDataB, fwdExWrite, fwdExDest, fwdExData,
                        rfWriteEn, rfWriteReg, rfWriteData);

   // immediate extension, sign unless the op is logical or SLBI
   assign imm5Ext = zeroExt ? {{(WORD_W-5){1'b0}}, instr[4:0]}
                            : {{(WORD_W-5){instr[4]}}, instr[4:0]};
   assign imm8Ext = zeroExt ? {{(WORD_W-8){1'b0}}, instr[7:0]}
                            : {{(WORD_W-8){instr[7]}}, instr[7:0]};
   assign immVal  = imm8Sel ? imm8Ext : imm5Ext;

   // I-format 2 writes rs/rd, R-format [4:2], I-format 1 [7:5]
   assign destIdx = imm8Sel ? instr[10:8] : (destSel ? instr[4:2] : instr[7:5]);

   assign accept = instrValid & ~haltSeen; // nothing enters after HALT

   // control half, cleared by reset so the bypass never sees stale writes
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         haltSeen <= 1'b0;
         exValid  <= 1'b0;
         exWrite  <= 1'b0;
         exHalt   <= 1'b0;
         exErr    <= 1'b0;
      end else begin
         haltSeen <= haltSeen | (accept & halt);
         exValid  <= accept;
         exWrite  <= accept & regWrite;
         exHalt   <= accept & halt;
         exErr    <= accept & illegal;
      end
   end

   // payload half
   always_ff @(posedge clk) begin
      exAluOp <= aluOp;
      exOpA   <= opA;
      exOpB   <= useImm ? immVal : regB;
      exDest  <= destIdx;
   end

endmodule

// ==== decode/instrDecoder.sv ====
// instruction decoder
// maps opcode and func field to the execute operation, the operand and
// immediate selects, the destination field and the write/halt/illegal flags
`timescale 1ns/1ps

module instrDecoder import coreTypesPkg::*; (
   input  logic [WORD_W-1:0] instr,
   output aluOpT             aluOp,
   output logic              useImm,   // operand B from immediate, not rt
   output logic              zeroExt,  // zero-extend instead of sign-extend
   output logic              imm8Sel,  // I-format 2, imm8 and rd in [10:8]
   output logic              destSel,  // 1: rd in [4:2], 0: rd in [7:5]
   output logic              regWrite,
   output logic              halt,
   output logic              illegal
);

   opcodeT opcode;
   funcT   func;

   assign opcode = opcodeT'(instr[15:11]);
   assign func   = funcT'(instr[1:0]);

   always_comb begin
      // defaults describe a writing I-format 1 instruction
      aluOp    = ALU_ADD;
      useImm   = 1'b1;
      zeroExt  = 1'b0;
      imm8Sel  = 1'b0;
      destSel  = 1'b0;
      regWrite = 1'b1;
      halt     = 1'b0;
      illegal  = 1'b0;

      case (opcode)
         OP_HALT: begin
            halt     = 1'b1;
            regWrite = 1'b0;
         end
         OP_NOP:  regWrite = 1'b0;
         OP_ADDI: aluOp = ALU_ADD;
         OP_SUBI: aluOp = ALU_SUB; // imm - rs
         OP_XORI: begin
            aluOp   = ALU_XOR;
            zeroExt = 1'b1;
         end
         OP_ANDNI: begin
            aluOp   = ALU_ANDN;
            zeroExt = 1'b1;
         end
         OP_ROLI: aluOp = ALU_ROL;   // only imm[3:0] matters
         OP_SLLI: aluOp = ALU_SLL;
         OP_RORI: aluOp = ALU_ROR;
         OP_SRLI: aluOp = ALU_SRL;
         OP_ARITH, OP_SHIFT: begin
            useImm  = 1'b0;
            destSel = 1'b1;
            case (func)
               FN_ADD_ROL:  aluOp = (opcode == OP_ARITH) ? ALU_ADD  : ALU_ROL;
               FN_SUB_SLL:  aluOp = (opcode == OP_ARITH) ? ALU_SUB  : ALU_SLL;
               FN_XOR_ROR:  aluOp = (opcode == OP_ARITH) ? ALU_XOR  : ALU_ROR;
               default:     aluOp = (opcode == OP_ARITH) ? ALU_ANDN : ALU_SRL;
            endcase
         end
         OP_SEQ, OP_SLT, OP_SLE, OP_SCO: begin
            useImm  = 1'b0;
            destSel = 1'b1;
            case (opcode)
               OP_SEQ:  aluOp = ALU_SEQ;
               OP_SLT:  aluOp = ALU_SLT;
               OP_SLE:  aluOp = ALU_SLE;
               default: aluOp = ALU_SCO;
            endcase
         end
         OP_BTR: begin
            aluOp   = ALU_BTR; // rs only, rd in [4:2]
            useImm  = 1'b0;
            destSel = 1'b1;
         end
         OP_LBI: begin
            aluOp   = ALU_PASSB;
            imm8Sel = 1'b1;     // signed imm8
         end
         OP_SLBI: begin
            aluOp   = ALU_SLBI;
            imm8Sel = 1'b1;
            zeroExt = 1'b1;
         end
         default: begin
            illegal  = 1'b1;   // retires flagged, writes nothing
            regWrite = 1'b0;
         end
      endcase
   end

endmodule

// ==== decode/regFile.sv ====
// register file
// eight 16-bit registers, two combinational read ports, one write port;
// no internal bypass, decode forwards around it
`timescale 1ns/1ps

module regFile import coreTypesPkg::*; (
   input  logic              clk,
   input  logic              arstN,
   input  logic [REG_W-1:0]  readRegA,
   input  logic [REG_W-1:0]  readRegB,
   output logic [WORD_W-1:0] readDataA,
   output logic [WORD_W-1:0] readDataB,
   input  logic              writeEn,
   input  logic [REG_W-1:0]  writeReg,
   input  logic [WORD_W-1:0] writeData
);

   logic [WORD_W-1:0] regs [2**REG_W];

   // all registers read as zero after reset
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < 2**REG_W; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn) begin
         regs[writeReg] <= writeData;
      end
   end

   assign readDataA = regs[readRegA]; // rs
   assign readDataB = regs[readRegB]; // rt

endmodule

// ==== procCore.f ====
+incdir+tests
common/coreTypesPkg.sv
decode/instrDecoder.sv
decode/regFile.sv
decode/decode.sv
verilog/execute.sv
verilog/result.sv
verilog/procCore.sv
tests/tbProcCore.sv

// ==== tests/tbProcCoreTests.svh ====
// procCore directed tests
// each task issues its sequence back to back and drains the pipeline
`ifndef TB_PROC_CORE_TESTS_SVH
`define TB_PROC_CORE_TESTS_SVH

// reset state, then LBI and SLBI loads
task automatic resetAndLoad();
   logic [31:0] rnd;
   @(negedge clk);
   checkVal("halted", 32'(halted), 32'd0);
   checkVal("wbValid", 32'(wbValid), 32'd0);
   issue(iFmt2(OP_LBI, 3'd1, 8'h85));   // negative byte, sign-extended
   issue(iFmt2(OP_LBI, 3'd2, 8'h7f));
   issue(iFmt2(OP_SLBI, 3'd1, 8'h3c));  // 0xff85 becomes 0x853c
   for (int r = 0; r < 8; r++) begin
      rnd = lcgNext();
      loadReg(3'(r), rnd[31:16]);
   end
   drain();
endtask

task automatic immediateOps();
   opcodeT      ops [8];
   logic [31:0] rnd;
   ops = '{OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI, OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI};
   for (int n = 0; n < 32; n++) begin
      rnd = lcgNext();
      issue(iFmt1(ops[n % 8], rnd[28:26], rnd[25:23], rnd[20:16]));
   end
   // extension edges
   issue(iFmt1(OP_ADDI, 3'd1, 3'd4, 5'h10));
   issue(iFmt1(OP_SUBI, 3'd2, 3'd5, 5'h1f));
   issue(iFmt1(OP_XORI, 3'd3, 3'd6, 5'h1f));  // zero-extended
   issue(iFmt1(OP_ANDNI, 3'd4, 3'd7, 5'h10));
   drain();
endtask

task automatic registerOps();
   opcodeT      ops [5];
   logic [31:0] rnd;
   int          sel;
   ops = '{OP_SEQ, OP_SLT, OP_SLE, OP_SCO, OP_BTR};
   loadReg(3'd1, 16'h8000);
   loadReg(3'd2, 16'h7fff);
   issue(rFmt(OP_SLT, 3'd1, 3'd2, 3'd3, 2'd0));    // most negative below max
   issue(rFmt(OP_SLT, 3'd2, 3'd1, 3'd4, 2'd0));
   issue(rFmt(OP_SLE, 3'd1, 3'd1, 3'd5, 2'd0));
   issue(rFmt(OP_SLE, 3'd2, 3'd1, 3'd6, 2'd0));
   issue(rFmt(OP_SEQ, 3'd2, 3'd2, 3'd7, 2'd0));
   issue(rFmt(OP_SCO, 3'd1, 3'd1, 3'd3, 2'd0));    // carry out set
   issue(rFmt(OP_SCO, 3'd1, 3'd2, 3'd4, 2'd0));
   issue(rFmt(OP_ARITH, 3'd1, 3'd2, 3'd5, 2'd1));  // rt minus rs wraps
   for (int n = 0; n < 52; n++) begin
      sel = n % 13;
      rnd = lcgNext();
      if (sel == 0)
         loadReg(rnd[18:16], rnd[31:16]);           // refresh a wide operand
      rnd = lcgNext();
      if (sel < 4)
         issue(rFmt(OP_ARITH, rnd[28:26], rnd[25:23], rnd[22:20], 2'(sel)));
      else if (sel < 8)
         issue(rFmt(OP_SHIFT, rnd[28:26], rnd[25:23], rnd[22:20], 2'(sel - 4)));
      else
         issue(rFmt(ops[sel - 8], rnd[28:26], rnd[25:23], rnd[22:20], rnd[17:16]));
   end
   drain();
endtask

// dependent chains at distances one, two and three, then a random mix
task automatic forwardChains();
   logic [31:0] rnd;
   for (int n = 0; n < 6; n++) issue(iFmt1(OP_ADDI, 3'd3, 3'd3, 5'd7));
   for (int n = 0; n < 6; n++) begin
      issue(iFmt1(OP_SUBI, 3'd4, 3'd4, 5'd3));
      issue(iFmt1(OP_XORI, 3'd5, 3'd5, 5'h15));
   end
   for (int n = 0; n < 6; n++) begin
      issue(rFmt(OP_ARITH, 3'd1, 3'd6, 3'd1, 2'd0));
      issue(rFmt(OP_ARITH, 3'd2, 3'd6, 3'd2, 2'd1));
      issue(rFmt(OP_SHIFT, 3'd7, 3'd3, 3'd7, 2'd0));
   end
   for (int n = 0; n < 40; n++) begin
      rnd = lcgNext();
      issue(rFmt(rnd[31] ? OP_ARITH : OP_SHIFT,
                 rnd[28:26], rnd[25:23], rnd[22:20], rnd[17:16]));
   end
   drain();
endtask

task automatic illegalAndNop();
   logic [4:0]  bad [6];
   logic [31:0] rnd;
   bad = '{5'b00010, 5'b00111, 5'b01100, 5'b10000, 5'b10001, 5'b10011};
   for (int n = 0; n < 6; n++) begin
      rnd = lcgNext();
      issue({bad[n], rnd[26:16]});
      issue({OP_NOP, rnd[30:20]});
   end
   // read back through ADDI of zero, nothing may have changed
   for (int r = 0; r < 8; r++) issue(iFmt1(OP_ADDI, 3'(r), 3'(r), 5'd0));
   drain();
endtask

task automatic haltBehavior();
   issue(iFmt1(OP_ADDI, 3'd1, 3'd2, 5'd9));
   issue(iFmt1(OP_XORI, 3'd2, 3'd3, 5'h0f));
   issue({OP_HALT, 11'd0});
   issue(iFmt1(OP_ADDI, 3'd3, 3'd3, 5'd1));  // dropped by decode
   issue(iFmt2(OP_LBI, 3'd4, 8'h12));
   drain();
   repeat (6) @(negedge clk);                // monitor rejects any late retire
   checkVal("halted", 32'(halted), 32'd1);
   resetCore();
   checkVal("halted", 32'(halted), 32'd0);
   issue(iFmt2(OP_LBI, 3'd6, 8'h9a));        // core runs again
   issue(iFmt1(OP_ADDI, 3'd6, 3'd7, 5'd1));
   drain();
endtask

`endif

// ==== tests/tbProcCore.sv ====
// procCore testbench
// drives instructions on the falling edge, predicts every retire with an
// ISA reference model and checks results, flags and the two-cycle latency
`timescale 1ns/1ps

module tbProcCore import coreTypesPkg::*; ();

   localparam longint CLK_NS    = 4;
   localparam longint MARGIN_NS = 400; // idle, drain and reset cycles

   // one predicted retire
   typedef struct packed {
      logic              write;
      logic [REG_W-1:0]  dest;
      logic [WORD_W-1:0] data;
      logic              err;
      logic              halt;
      logic [31:0]       issued;  // rising edges seen when presented
   } expT;

   logic              clk;
   logic              arstN;
   logic [WORD_W-1:0] instr;
   logic              instrValid;
   logic              wbValid;
   logic              wbWrite;
   logic [REG_W-1:0]  wbReg;
   logic [WORD_W-1:0] wbData;
   logic              wbErr;
   logic              halted;

   logic [WORD_W-1:0] modelRegs [8];
   expT               expQ [$];
   expT               head;
   logic              haltIssued;
   logic              haltRetired;      // model view of the halted level
   logic [31:0]       lcgState = 32'hc1e6_ce12;
   int                edgeCount = 0;
   int                issuedCount = 0;
   int                checkCount = 0;
   int                mismatchCount = 0;
   int                otherCount = 0;

   procCore u_procCore (
      .clk        (clk),
      .arstN      (arstN),
      .instr      (instr),
      .instrValid (instrValid),
      .wbValid    (wbValid),
      .wbWrite    (wbWrite),
      .wbReg      (wbReg),
      .wbData     (wbData),
      .wbErr      (wbErr),
      .halted     (halted)
   );

   always #2 clk = ~clk;

   always @(posedge clk) edgeCount++;

   function automatic logic [31:0] lcgNext();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   function automatic logic [WORD_W-1:0] rotl(input logic [WORD_W-1:0] v, input logic [3:0] n);
      return (v << n) | (v >> (5'd16 - n)); // n of 0 leaves v
   endfunction

   // instruction encoders
   function automatic logic [WORD_W-1:0] iFmt1(input opcodeT op, input logic [2:0] rs,
                                               input logic [2:0] rd, input logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic logic [WORD_W-1:0] rFmt(input opcodeT op, input logic [2:0] rs,
                                              input logic [2:0] rt, input logic [2:0] rd,
                                              input logic [1:0] fn);
      return {op, rs, rt, rd, fn};
   endfunction

   function automatic logic [WORD_W-1:0] iFmt2(input opcodeT op, input logic [2:0] rs,
                                               input logic [7:0] imm8);
      return {op, rs, imm8};
   endfunction

   // ISA reference that updates the model registers in program order
   function automatic expT predict(input logic [WORD_W-1:0] w);
      expT               e;
      opcodeT            op;
      logic [WORD_W-1:0] a;
      logic [WORD_W-1:0] b;
      logic [WORD_W-1:0] sImm;
      logic [WORD_W-1:0] zImm;
      logic [WORD_W-1:0] r;
      logic [31:0]       sum;
      op   = opcodeT'(w[15:11]);
      a    = modelRegs[w[10:8]];  // rs
      b    = modelRegs[w[7:5]];   // rt
      sImm = {{11{w[4]}}, w[4:0]};
      zImm = {11'd0, w[4:0]};
      sum  = 32'(a) + 32'(b);     // carry when above 16 bits
      r    = '0;
      e    = '0;
      e.write = 1'b1;
      e.dest  = w[7:5];
      case (op)
         OP_HALT: begin
            e.write = 1'b0;
            e.halt  = 1'b1;
         end
         OP_NOP:   e.write = 1'b0;
         OP_ADDI:  r = a + sImm;
         OP_SUBI:  r = sImm - a;
         OP_XORI:  r = a ^ zImm;
         OP_ANDNI: r = a & ~zImm;
         OP_ROLI:  r = rotl(a, w[3:0]);
         OP_SLLI:  r = a << w[3:0];
         OP_RORI:  r = rotl(a, 4'd0 - w[3:0]); // right by n is left by 16-n
         OP_SRLI:  r = a >> w[3:0];
         OP_ARITH, OP_SHIFT, OP_SEQ, OP_SLT, OP_SLE, OP_SCO, OP_BTR: begin
            e.dest = w[4:2];
            case ({op, w[1:0]})
               {OP_ARITH, 2'd0}: r = a + b;
               {OP_ARITH, 2'd1}: r = b - a;
               {OP_ARITH, 2'd2}: r = a ^ b;
               {OP_ARITH, 2'd3}: r = a & ~b;
               {OP_SHIFT, 2'd0}: r = rotl(a, b[3:0]);
               {OP_SHIFT, 2'd1}: r = a << b[3:0];
               {OP_SHIFT, 2'd2}: r = rotl(a, 4'd0 - b[3:0]);
               {OP_SHIFT, 2'd3}: r = a >> b[3:0];
               default: begin
                  if (op == OP_SEQ) r = {15'd0, a == b};
                  if (op == OP_SLT) r = {15'd0, $signed(a) < $signed(b)};
                  if (op == OP_SLE) r = {15'd0, $signed(a) <= $signed(b)};
                  if (op == OP_SCO) r = {15'd0, sum > 32'h0000_ffff};
                  if (op == OP_BTR)
                     for (int i = 0; i < 16; i++) r = {r[14:0], a[i]}; // lsb ends on top
               end
            endcase
         end
         OP_LBI: begin
            e.dest = w[10:8];
            r = {{8{w[7]}}, w[7:0]};
         end
         OP_SLBI: begin
            e.dest = w[10:8];
            r = (a << 8) | {8'd0, w[7:0]};
         end
         default: begin
            e.write = 1'b0;  // unlisted opcode
            e.err   = 1'b1;
         end
      endcase
      e.data = r;
      if (e.write) modelRegs[e.dest] = r;
      return e;
   endfunction

   task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
      checkCount++;
      if (got !== exp) begin
         mismatchCount++;
         $display("mismatch t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      end
   endtask

   task automatic reportCounts();
      $display("checks %0d, mismatches %0d, other errors %0d",
               checkCount, mismatchCount, otherCount);
   endtask

   // present one instruction per cycle until drain lowers valid
   task automatic issue(input logic [WORD_W-1:0] w);
      expT e;
      @(negedge clk);
      instr      = w;
      instrValid = 1'b1;
      issuedCount++;
      if (!haltIssued) begin
         e = predict(w);
         e.issued = edgeCount;
         expQ.push_back(e);
         haltIssued = e.halt;
      end
   endtask

   task automatic loadReg(input logic [2:0] r, input logic [WORD_W-1:0] v);
      issue(iFmt2(OP_LBI, r, v[15:8]));
      issue(iFmt2(OP_SLBI, r, v[7:0]));
   endtask

   // stop issuing and wait for everything outstanding to retire
   task automatic drain();
      int waited;
      @(negedge clk);
      instrValid = 1'b0;
      instr      = '0;
      waited     = 0;
      while (expQ.size() != 0 && waited < 8) begin
         @(negedge clk);
         waited++;
      end
      if (expQ.size() != 0) begin
         otherCount++;
         $display("error at %0t: %0d instructions never retired", $time, expQ.size());
         expQ.delete();
      end
   endtask

   task automatic resetCore();
      @(negedge clk);
      instrValid = 1'b0;
      arstN      = 1'b0;
      @(posedge clk);
      expQ.delete();
      haltIssued  = 1'b0;
      haltRetired = 1'b0;
      for (int r = 0; r < 8; r++) modelRegs[r] = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      arstN = 1'b1;
   endtask

`include "tbProcCoreTests.svh"

   // compare each retire against the oldest prediction
   always @(negedge clk) begin
      if (arstN) begin
         if (wbValid && expQ.size() == 0) begin
            otherCount++;
            $display("error at %0t: retire seen with no instruction outstanding", $time);
         end else if (wbValid) begin
            head = expQ.pop_front();
            checkVal("latency", edgeCount - head.issued, 32'd2);
            checkVal("wbWrite", 32'(wbWrite), 32'(head.write));
            checkVal("wbErr", 32'(wbErr), 32'(head.err));
            checkVal("halted", 32'(halted), 32'(head.halt | haltRetired));
            if (head.write) begin
               checkVal("wbReg", 32'(wbReg), 32'(head.dest));
               checkVal("wbData", 32'(wbData), 32'(head.data));
            end
            haltRetired = haltRetired | head.halt;
         end else begin
            checkVal("halted", 32'(halted), 32'(haltRetired));
         end
      end
   end

   initial begin
      longint limit;
      bit     expired;
      expired = 1'b0;
      limit   = MARGIN_NS;
      while (!expired) begin
         @(posedge clk);
         limit   = longint'(issuedCount) * CLK_NS + MARGIN_NS;
         expired = ($time > limit);
      end
      $display("error at %0t: run did not finish within %0d ns", $time, limit);
      reportCounts();
      $display("TB FAILED");
      $finish;
   end

   initial begin
      clk        = 1'b0;
      arstN      = 1'b0;
      instr      = '0;
      instrValid = 1'b0;
      resetCore();
      resetAndLoad();
      immediateOps();
      registerOps();
      forwardChains();
      illegalAndNop();
      haltBehavior();
      reportCounts();
      if (mismatchCount == 0 && otherCount == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

// ==== verilog/execute.sv ====
// execute stage
// ALU, shifter/rotator, signed set-condition, carry-out and bit reverse;
// result goes back to decode combinationally and into the result register
`timescale 1ns/1ps

module execute import coreTypesPkg::*; (
   input  logic              clk,
   input  logic              arstN,
   input  logic              exValid,
   input  aluOpT             exAluOp,
   input  logic [WORD_W-1:0] exOpA,
   input  logic [WORD_W-1:0] exOpB,
   input  logic [REG_W-1:0]  exDest,
   input  logic              exWrite,
   input  logic              exHalt,
   input  logic              exErr,
   output logic [WORD_W-1:0] fwdExData,
   output logic              rsValid,
   output logic [WORD_W-1:0] rsResult,
   output logic [REG_W-1:0]  rsDest,
   output logic              rsWrite,
   output logic              rsHalt,
   output logic              rsErr
);

   logic [WORD_W:0]     carrySum;  // 17 bits, msb is SCO
   logic [3:0]          shAmt;
   logic [2*WORD_W-1:0] rolWide;
   logic [2*WORD_W-1:0] rorWide;
   logic [WORD_W-1:0]   bitRev;
   logic                sLess;
   logic [WORD_W-1:0]   aluResult;

   assign carrySum = {1'b0, exOpA} + {1'b0, exOpB};
   assign shAmt    = exOpB[3:0];                     // only low 4 bits count
   assign rolWide  = {exOpA, exOpA} << shAmt;        // upper half is rotate left
   assign rorWide  = {exOpA, exOpA} >> shAmt;        // lower half is rotate right
   assign sLess    = $signed(exOpA) < $signed(exOpB);

   always_comb begin
      for (int i = 0; i < WORD_W; i++) begin
         bitRev[i] = exOpA[WORD_W-1-i];
      end
   end

   always_comb begin
      case (exAluOp)
         ALU_ADD:   aluResult = carrySum[WORD_W-1:0];
         ALU_SUB:   aluResult = exOpB - exOpA;       // rt - rs, imm - rs
         ALU_XOR:   aluResult = exOpA ^ exOpB;
         ALU_ANDN:  aluResult = exOpA & ~exOpB;
         ALU_ROL:   aluResult = rolWide[2*WORD_W-1:WORD_W];
         ALU_SLL:   aluResult = exOpA << shAmt;
         ALU_ROR:   aluResult = rorWide[WORD_W-1:0];
         ALU_SRL:   aluResult = exOpA >> shAmt;
         ALU_SEQ:   aluResult = {{(WORD_W-1){1'b0}}, exOpA == exOpB};
         ALU_SLT:   aluResult = {{(WORD_W-1){1'b0}}, sLess};
         ALU_SLE:   aluResult = {{(WORD_W-1){1'b0}}, sLess | (exOpA == exOpB)};
         ALU_SCO:   aluResult = {{(WORD_W-1){1'b0}}, carrySum[WORD_W]};
         ALU_BTR:   aluResult = bitRev;
         ALU_PASSB: aluResult = exOpB;
         ALU_SLBI:  aluResult = {exOpA[7:0], exOpB[7:0]}; // b already zero-extended
         default:   aluResult = '0;
      endcase
   end

   assign fwdExData = aluResult;

   // flags arrive already qualified by decode
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         rsValid <= 1'b0;
         rsWrite <= 1'b0;
         rsHalt  <= 1'b0;
         rsErr   <= 1'b0;
      end else begin
         rsValid <= exValid;
         rsWrite <= exWrite;
         rsHalt  <= exHalt;
         rsErr   <= exErr;
      end
   end

   always_ff @(posedge clk) begin
      rsResult <= aluResult;
      rsDest   <= exDest;
   end

endmodule

// ==== verilog/procCore.sv ====
// procCore top level
// three-stage 16-bit integer core: decode, execute and result,
// one instruction accepted per cycle, two cycles from issue to retire
`timescale 1ns/1ps

module procCore import coreTypesPkg::*; (
   input  logic              clk,
   input  logic              arstN,
   input  logic [WORD_W-1:0] instr,
   input  logic              instrValid,
   output logic              wbValid,
   output logic              wbWrite,
   output logic [REG_W-1:0]  wbReg,
   output logic [WORD_W-1:0] wbData,
   output logic              wbErr,
   output logic              halted
);

   // decode to execute
   logic              exValid;
   aluOpT             exAluOp;
   logic [WORD_W-1:0] exOpA;
   logic [WORD_W-1:0] exOpB;
   logic [REG_W-1:0]  exDest;
   logic              exWrite;
   logic              exHalt;
   logic              exErr;
   logic [WORD_W-1:0] fwdExData;
   // execute to result
   logic              rsValid;
   logic [WORD_W-1:0] rsResult;
   logic [REG_W-1:0]  rsDest;
   logic              rsWrite;
   logic              rsHalt;
   logic              rsErr;
   // result write bus back into decode
   logic              rfWriteEn;
   logic [REG_W-1:0]  rfWriteReg;
   logic [WORD_W-1:0] rfWriteData;

   decode u_decode (
      .clk         (clk),
      .arstN       (arstN),
      .instr       (instr),
      .instrValid  (instrValid),
      .fwdExData   (fwdExData),
      .fwdExDest   (exDest),      // the instruction now in execute
      .fwdExWrite  (exWrite),
      .rfWriteEn   (rfWriteEn),
      .rfWriteReg  (rfWriteReg),
      .rfWriteData (rfWriteData),
      .exValid     (exValid),
      .exAluOp     (exAluOp),
      .exOpA       (exOpA),
      .exOpB       (exOpB),
      .exDest      (exDest),
      .exWrite     (exWrite),
      .exHalt      (exHalt),
      .exErr       (exErr)
   );

   execute u_execute (
      .clk       (clk),
      .arstN     (arstN),
      .exValid   (exValid),
      .exAluOp   (exAluOp),
      .exOpA     (exOpA),
      .exOpB     (exOpB),
      .exDest    (exDest),
      .exWrite   (exWrite),
      .exHalt    (exHalt),
      .exErr     (exErr),
      .fwdExData (fwdExData),
      .rsValid   (rsValid),
      .rsResult  (rsResult),
      .rsDest    (rsDest),
      .rsWrite   (rsWrite),
      .rsHalt    (rsHalt),
      .rsErr     (rsErr)
   );

   result u_result (
      .clk         (clk),
      .arstN       (arstN),
      .rsValid     (rsValid),
      .rsResult    (rsResult),
      .rsDest      (rsDest),
      .rsWrite     (rsWrite),
      .rsHalt      (rsHalt),
      .rsErr       (rsErr),
      .rfWriteEn   (rfWriteEn),
      .rfWriteReg  (rfWriteReg),
      .rfWriteData (rfWriteData),
      .wbValid     (wbValid),
      .wbWrite     (wbWrite),
      .wbReg       (wbReg),
      .wbData      (wbData),
      .wbErr       (wbErr),
      .halted      (halted)
   );

endmodule

// ==== verilog/result.sv ====
// result stage
// drives the register-file write, reports each retired instruction and
// holds the halted level from the retiring HALT until reset
`timescale 1ns/1ps

module result import coreTypesPkg::*; (
   input  logic              clk,
   input  logic              arstN,
   input  logic              rsValid,
   input  logic [WORD_W-1:0] rsResult,
   input  logic [REG_W-1:0]  rsDest,
   input  logic              rsWrite,
   input  logic              rsHalt,
   input  logic              rsErr,
   output logic              rfWriteEn,
   output logic [REG_W-1:0]  rfWriteReg,
   output logic [WORD_W-1:0] rfWriteData,
   output logic              wbValid,
   output logic              wbWrite,
   output logic [REG_W-1:0]  wbReg,
   output logic [WORD_W-1:0] wbData,
   output logic              wbErr,
   output logic              halted
);

   logic haltLatched;
   logic haltRetire;

   assign haltRetire  = rsValid & rsHalt;

   assign rfWriteEn   = rsValid & rsWrite;   // array written at the next edge
   assign rfWriteReg  = rsDest;
   assign rfWriteData = rsResult;

   assign wbValid = rsValid;
   assign wbWrite = rfWriteEn;
   assign wbReg   = rsDest;
   assign wbData  = rsResult;
   assign wbErr   = rsValid & rsErr;
   assign halted  = haltLatched | haltRetire; // rises with the HALT's wbValid

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN)
         haltLatched <= 1'b0;
      else if (haltRetire)
         haltLatched <= 1'b1;                 // only reset clears it
   end

endmodule
